// File: design/cache_pkg.sv
package cache_pkg;

    // ----------------------------------------
    // Address split
    // ----------------------------------------

    // Byte address seen by the load/store unit.
    localparam int addr_w = 32;

    // Byte offset inside one cache line.
    localparam int offset_w = 4;

    // Line address, the byte address without its offset.
    localparam int line_addr_w = addr_w - offset_w;

    // Set index, the low end of the line address.
    localparam int index_w = 9;

    // Tag stored with a victim line.
    localparam int tag_w = 19;

    // ----------------------------------------
    // Line and MSHR sizes
    // ----------------------------------------

    localparam int line_w = 128;

    localparam int mshr_rows = 8;
    localparam int mshr_ptr_w = 3;

    // Lookup opcode issued by the pipeline.
    typedef enum logic [1:0] {
        dop_none = 2'd0,
        dop_r    = 2'd1,
        dop_w    = 2'd2
    } dop_t;

endpackage

// File: design/mem_pkg.sv
package mem_pkg;

    // ----------------------------------------
    // Memory bus
    // ----------------------------------------

    // Memory is addressed by whole lines.
    localparam int mem_addr_w = 28;

    // One transfer carries one full line.
    localparam int mem_data_w = 128;

    // Request command on the memory port.
    typedef enum logic {
        cmd_read  = 1'b0,
        cmd_write = 1'b1
    } mem_cmd_t;

endpackage

// File: design/writeback_handler.sv
module writeback_handler (
    input  logic                           g,
    input  logic                           rst,
    input  logic                           wb_valid,
    input  logic [mem_pkg::mem_addr_w-1:0] wb_addr,
    input  logic [mem_pkg::mem_data_w-1:0] wb_data,
    output logic                           wb_accept,
    output logic                           wbq_valid,
    output logic [mem_pkg::mem_addr_w-1:0] wbq_addr,
    output logic [mem_pkg::mem_data_w-1:0] wbq_data,
    input  logic                           wbq_ready
);

    always_ff @(posedge g)
    begin
        if (rst)
        begin
            wbq_valid <= 1'b0;
        end
        else if (!wbq_valid)
        begin
            wbq_valid <= wb_valid;
        end
        else if (wbq_ready)
        begin
            wbq_valid <= 1'b0;
        end
    end

    // Fields load only while idle, so they stay put until memory takes them.
    always_ff @(posedge g)
    begin
        if (!wbq_valid && wb_valid)
        begin
            wbq_addr <= wb_addr;
            wbq_data <= wb_data;
        end
    end

    assign wb_accept = wbq_valid && wbq_ready;

endmodule

// File: design/load_handler.sv
module load_handler (
    input  logic                           g,
    input  logic                           rst,
    input  logic                           ld_valid,
    input  logic [mem_pkg::mem_addr_w-1:0] ld_addr,
    output logic                           ld_accept,
    output logic                           ldq_valid,
    output logic [mem_pkg::mem_addr_w-1:0] ldq_addr,
    input  logic                           ldq_ready
);

    always_ff @(posedge g)
    begin
        if (rst)
        begin
            ldq_valid <= 1'b0;
        end
        else if (!ldq_valid)
        begin
            ldq_valid <= ld_valid;
        end
        else if (ldq_ready)
        begin
            ldq_valid <= 1'b0;
        end
    end

    always_ff @(posedge g)
    begin
        if (!ldq_valid && ld_valid)
        begin
            ldq_addr <= ld_addr;
        end
    end

    // The MSHR marks the row issued on this pulse.
    assign ld_accept = ldq_valid && ldq_ready;

endmodule

// File: design/mem_listener.sv
module mem_listener (
    input  logic                                g,
    input  logic                                rst,
    input  logic                                mem_resp_valid,
    input  logic [mem_pkg::mem_data_w-1:0]      mem_resp_data,
    input  logic [cache_pkg::line_addr_w-1:0]   retire_addr,
    output logic                                received,
    output logic                                refill_valid,
    output logic [cache_pkg::line_addr_w-1:0]   refill_addr,
    output logic [cache_pkg::line_w-1:0]        refill_data
);

    // Replies return in read order, so each one belongs to the retire row.
    assign received = mem_resp_valid;

    always_ff @(posedge g)
    begin
        if (rst)
        begin
            refill_valid <= 1'b0;
        end
        else
        begin
            refill_valid <= mem_resp_valid;
        end
    end

    always_ff @(posedge g)
    begin
        if (mem_resp_valid)
        begin
            refill_addr <= retire_addr;
            refill_data <= mem_resp_data;
        end
    end

endmodule

// File: design/mem_request_mux.sv
module mem_request_mux (
    input  logic                           g,
    input  logic                           rst,
    input  logic                           wbq_valid,
    input  logic [mem_pkg::mem_addr_w-1:0] wbq_addr,
    input  logic [mem_pkg::mem_data_w-1:0] wbq_data,
    input  logic                           ldq_valid,
    input  logic [mem_pkg::mem_addr_w-1:0] ldq_addr,
    output logic                           wbq_ready,
    output logic                           ldq_ready,
    output logic                           mem_req_valid,
    output mem_pkg::mem_cmd_t              mem_cmd,
    output logic [mem_pkg::mem_addr_w-1:0] mem_req_addr,
    output logic [mem_pkg::mem_data_w-1:0] mem_req_data,
    input  logic                           mem_req_ready
);

    logic              lock_q;
    mem_pkg::mem_cmd_t grant_q;
    logic              sel_wb;

    // A stalled source keeps the port; otherwise writeback wins each new grant.
    assign sel_wb = lock_q ? (grant_q == mem_pkg::cmd_write) : wbq_valid;

    assign mem_req_valid = sel_wb ? wbq_valid : ldq_valid;
    assign mem_cmd       = sel_wb ? mem_pkg::cmd_write : mem_pkg::cmd_read;
    assign mem_req_addr  = sel_wb ? wbq_addr : ldq_addr;
    assign mem_req_data  = sel_wb ? wbq_data : '0;

    assign wbq_ready = mem_req_ready && sel_wb;
    assign ldq_ready = mem_req_ready && !sel_wb;

    always_ff @(posedge g)
    begin
        if (rst)
        begin
            lock_q  <= 1'b0;
            grant_q <= mem_pkg::cmd_read;
        end
        else if (mem_req_valid && !mem_req_ready)
        begin
            lock_q  <= 1'b1;
            grant_q <= mem_cmd;
        end
        else if (mem_req_valid)
        begin
            lock_q <= 1'b0;
        end
    end

endmodule

// File: design/miss_handler.sv
module miss_handler (
    input  logic                                g,
    input  logic                                rst,
    input  cache_pkg::dop_t                     op,
    input  logic [cache_pkg::addr_w-1:0]        addr,
    input  logic                                hit,
    input  logic                                dirty,
    input  logic [cache_pkg::tag_w-1:0]         tag,
    input  logic [cache_pkg::line_w-1:0]        data,
    output logic                                mshr_full,
    output logic                                mem_req_valid,
    output mem_pkg::mem_cmd_t                   mem_cmd,
    output logic [mem_pkg::mem_addr_w-1:0]      mem_req_addr,
    output logic [mem_pkg::mem_data_w-1:0]      mem_req_data,
    input  logic                                mem_req_ready,
    input  logic                                mem_resp_valid,
    input  logic [mem_pkg::mem_data_w-1:0]      mem_resp_data,
    output logic                                refill_valid,
    output logic [cache_pkg::line_addr_w-1:0]   refill_addr,
    output logic [cache_pkg::line_w-1:0]        refill_data
);

    // ----------------------------------------
    // MSHR rows
    // ----------------------------------------

    logic [cache_pkg::mshr_rows-1:0]   ent_valid;
    logic [cache_pkg::mshr_rows-1:0]   ent_wb;
    logic [cache_pkg::mshr_rows-1:0]   ent_issued;
    logic [cache_pkg::line_addr_w-1:0] ent_line [cache_pkg::mshr_rows];
    logic [cache_pkg::tag_w-1:0]       ent_tag  [cache_pkg::mshr_rows];
    logic [cache_pkg::line_w-1:0]      ent_data [cache_pkg::mshr_rows];

    logic [cache_pkg::mshr_ptr_w-1:0]  alloc_ptr;
    logic [cache_pkg::mshr_ptr_w-1:0]  issue_ptr;
    logic [cache_pkg::mshr_ptr_w-1:0]  retire_ptr;

    logic [cache_pkg::line_addr_w-1:0] req_line;
    logic [cache_pkg::mshr_rows-1:0]   line_match;
    logic                              is_miss;
    logic                              merged;
    logic                              alloc;

    logic                              wb_valid;
    logic [mem_pkg::mem_addr_w-1:0]    wb_addr;
    logic [mem_pkg::mem_data_w-1:0]    wb_data;
    logic                              wb_accept;
    logic                              wbq_valid;
    logic [mem_pkg::mem_addr_w-1:0]    wbq_addr;
    logic [mem_pkg::mem_data_w-1:0]    wbq_data;
    logic                              wbq_ready;
    logic                              ld_valid;
    logic [mem_pkg::mem_addr_w-1:0]    ld_addr;
    logic                              ld_accept;
    logic                              ldq_valid;
    logic [mem_pkg::mem_addr_w-1:0]    ldq_addr;
    logic                              ldq_ready;
    logic                              received;
    logic [cache_pkg::line_addr_w-1:0] retire_addr;

    assign req_line = addr[cache_pkg::addr_w-1:cache_pkg::offset_w];
    assign is_miss  = (op == cache_pkg::dop_r || op == cache_pkg::dop_w) && !hit;

    always_comb
    begin
        for (int i = 0; i < cache_pkg::mshr_rows; i++)
        begin
            line_match[i] = ent_valid[i] && (ent_line[i] == req_line);
        end
    end

    // The registered refill is the line that has left the MSHR but is not in the cache yet.
    assign merged = (|line_match) || (refill_valid && refill_addr == req_line);
    assign alloc  = is_miss && !merged && !ent_valid[alloc_ptr];

    assign mshr_full = &ent_valid;

    always_ff @(posedge g)
    begin
        if (rst)
        begin
            ent_valid  <= '0;
            ent_wb     <= '0;
            ent_issued <= '0;
        end
        else
        begin
            if (alloc)
            begin
                ent_valid[alloc_ptr]  <= 1'b1;
                ent_wb[alloc_ptr]     <= dirty;
                ent_issued[alloc_ptr] <= 1'b0;
            end
            if (wb_accept)
            begin
                ent_wb[issue_ptr] <= 1'b0;
            end
            if (ld_accept)
            begin
                ent_issued[issue_ptr] <= 1'b1;
            end
            if (received)
            begin
                ent_valid[retire_ptr] <= 1'b0;
            end
        end
    end

    always_ff @(posedge g)
    begin
        if (alloc)
        begin
            ent_line[alloc_ptr] <= req_line;
            ent_tag[alloc_ptr]  <= tag;
            ent_data[alloc_ptr] <= data;
        end
    end

    // Rows are taken, issued and retired in the same circular order.
    always_ff @(posedge g)
    begin
        if (rst)
        begin
            alloc_ptr  <= '0;
            issue_ptr  <= '0;
            retire_ptr <= '0;
        end
        else
        begin
            if (alloc)
            begin
                alloc_ptr <= alloc_ptr + (cache_pkg::mshr_ptr_w)'(1);
            end
            if (ld_accept)
            begin
                issue_ptr <= issue_ptr + (cache_pkg::mshr_ptr_w)'(1);
            end
            if (received)
            begin
                retire_ptr <= retire_ptr + (cache_pkg::mshr_ptr_w)'(1);
            end
        end
    end

    // ----------------------------------------
    // Memory side
    // ----------------------------------------

    // A dirty victim goes out first; the line read waits until it is taken.
    assign wb_valid = ent_valid[issue_ptr] && ent_wb[issue_ptr];
    assign wb_addr  = {ent_tag[issue_ptr], ent_line[issue_ptr][cache_pkg::index_w-1:0]};
    assign wb_data  = ent_data[issue_ptr];

    assign ld_valid = ent_valid[issue_ptr] && !ent_wb[issue_ptr] && !ent_issued[issue_ptr];
    assign ld_addr  = ent_line[issue_ptr];

    assign retire_addr = ent_line[retire_ptr];

    writeback_handler i_writeback_handler (
        .g         (g),
        .rst       (rst),
        .wb_valid  (wb_valid),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .wb_accept (wb_accept),
        .wbq_valid (wbq_valid),
        .wbq_addr  (wbq_addr),
        .wbq_data  (wbq_data),
        .wbq_ready (wbq_ready)
    );

    load_handler i_load_handler (
        .g         (g),
        .rst       (rst),
        .ld_valid  (ld_valid),
        .ld_addr   (ld_addr),
        .ld_accept (ld_accept),
        .ldq_valid (ldq_valid),
        .ldq_addr  (ldq_addr),
        .ldq_ready (ldq_ready)
    );

    mem_request_mux i_mem_request_mux (
        .g             (g),
        .rst           (rst),
        .wbq_valid     (wbq_valid),
        .wbq_addr      (wbq_addr),
        .wbq_data      (wbq_data),
        .ldq_valid     (ldq_valid),
        .ldq_addr      (ldq_addr),
        .wbq_ready     (wbq_ready),
        .ldq_ready     (ldq_ready),
        .mem_req_valid (mem_req_valid),
        .mem_cmd       (mem_cmd),
        .mem_req_addr  (mem_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready)
    );

    mem_listener i_mem_listener (
        .g              (g),
        .rst            (rst),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .retire_addr    (retire_addr),
        .received       (received),
        .refill_valid   (refill_valid),
        .refill_addr    (refill_addr),
        .refill_data    (refill_data)
    );

endmodule

// File: design/dcache_miss_path.sv
module dcache_miss_path (
    input  logic                                g,
    input  logic                                rst,
    input  cache_pkg::dop_t                     op,
    input  logic [cache_pkg::addr_w-1:0]        addr,
    input  logic                                hit,
    input  logic                                dirty,
    input  logic [cache_pkg::tag_w-1:0]         tag,
    input  logic [cache_pkg::line_w-1:0]        data,
    output logic                                mshr_full,
    output logic                                mem_req_valid,
    output mem_pkg::mem_cmd_t                   mem_cmd,
    output logic [mem_pkg::mem_addr_w-1:0]      mem_req_addr,
    output logic [mem_pkg::mem_data_w-1:0]      mem_req_data,
    input  logic                                mem_req_ready,
    input  logic                                mem_resp_valid,
    input  logic [mem_pkg::mem_data_w-1:0]      mem_resp_data,
    output logic                                refill_valid,
    output logic [cache_pkg::line_addr_w-1:0]   refill_addr,
    output logic [cache_pkg::line_w-1:0]        refill_data
);

    // Miss path of the write-back data cache in the load/store unit.
    miss_handler i_miss_handler (
        .g              (g),
        .rst            (rst),
        .op             (op),
        .addr           (addr),
        .hit            (hit),
        .dirty          (dirty),
        .tag            (tag),
        .data           (data),
        .mshr_full      (mshr_full),
        .mem_req_valid  (mem_req_valid),
        .mem_cmd        (mem_cmd),
        .mem_req_addr   (mem_req_addr),
        .mem_req_data   (mem_req_data),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .refill_valid   (refill_valid),
        .refill_addr    (refill_addr),
        .refill_data    (refill_data)
    );

endmodule

// File: bench/dcache_miss_path_tb.sv
module dcache_miss_path_tb;

    localparam int len_single = 40;
    localparam int len_dirty = 60;
    localparam int len_merge = 60;
    localparam int len_stall = 300;
    localparam int len_full = 60;
    localparam int len_mix = 1500;
    localparam int max_latency = 4;
    localparam int cycle_limit =
        4 * (len_single + len_dirty + len_merge + len_stall + len_full + len_mix) * max_latency;

    logic                                g;
    logic                                rst;
    cache_pkg::dop_t                     op;
    logic [cache_pkg::addr_w-1:0]        addr;
    logic                                hit;
    logic                                dirty;
    logic [cache_pkg::tag_w-1:0]         tag;
    logic [cache_pkg::line_w-1:0]        data;
    logic                                mshr_full;
    logic                                mem_req_valid;
    mem_pkg::mem_cmd_t                   mem_cmd;
    logic [mem_pkg::mem_addr_w-1:0]      mem_req_addr;
    logic [mem_pkg::mem_data_w-1:0]      mem_req_data;
    logic                                mem_req_ready;
    logic                                mem_resp_valid;
    logic [mem_pkg::mem_data_w-1:0]      mem_resp_data;
    logic                                refill_valid;
    logic [cache_pkg::line_addr_w-1:0]   refill_addr;
    logic [cache_pkg::line_w-1:0]        refill_data;

    // ----------------------------------------
    // Testbench state
    // ----------------------------------------

    logic [31:0]       lfsr = 32'h92f0fa71;
    int                cycles = 0;
    string             test_name = "reset";
    bit                stall_mode = 0;
    bit                hold_resp = 0;

    // Expected memory requests, in the order the MSHR must issue them.
    mem_pkg::mem_cmd_t exp_cmd_q [$];
    logic [27:0]       exp_addr_q [$];
    logic [127:0]      exp_data_q [$];

    // Reference MSHR contents and the line being installed.
    logic [27:0]       ent_line_q [$];
    logic [127:0]      ent_fill_q [$];
    bit                install_valid = 0;
    logic [27:0]       install_line;
    logic [127:0]      install_data;
    logic [127:0]      shadow [logic [27:0]];

    // Memory model.
    logic [127:0]      mem_store [logic [27:0]];
    logic [127:0]      resp_q [$];
    int                due_q [$];

    bit                prev_stall = 0;
    mem_pkg::mem_cmd_t prev_cmd;
    logic [27:0]       prev_addr;
    logic [127:0]      prev_data;

    dcache_miss_path i_dcache_miss_path (
        .g              (g),
        .rst            (rst),
        .op             (op),
        .addr           (addr),
        .hit            (hit),
        .dirty          (dirty),
        .tag            (tag),
        .data           (data),
        .mshr_full      (mshr_full),
        .mem_req_valid  (mem_req_valid),
        .mem_cmd        (mem_cmd),
        .mem_req_addr   (mem_req_addr),
        .mem_req_data   (mem_req_data),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .refill_valid   (refill_valid),
        .refill_addr    (refill_addr),
        .refill_data    (refill_data)
    );

    initial
    begin
        g = 1'b0;
        forever #50 g = ~g;
    end

    always @(posedge g)
    begin
        cycles = cycles + 1;
        if (cycles > cycle_limit)
        begin
            $display("timeout in %s, the miss path stopped making progress", test_name);
            $display("Testbench failed");
            $fatal(1, "run stopped at cycle limit");
        end
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);
        end
        return r;
    endfunction

    // Contents of a line that memory has never seen written.
    function automatic logic [127:0] mem_fill(input logic [27:0] line);
        return {line, 4'h1, ~line, 4'h2, line ^ 28'h0c3a5f1, 4'h3, line + 28'h1234567, 4'h4};
    endfunction

    function automatic logic [27:0] pool_line(input logic [2:0] k);
        return {16'h0a5c, k, 9'(k) ^ 9'h0c0};
    endfunction

    // Reference MSHR rule: does this lookup take a new entry?
    function automatic bit ref_accepts(input cache_pkg::dop_t o, input logic h,
                                       input logic [27:0] line);
        if (!(o == cache_pkg::dop_r || o == cache_pkg::dop_w) || h)
        begin
            return 0;
        end
        foreach (ent_line_q[i])
        begin
            if (ent_line_q[i] == line)
            begin
                return 0;
            end
        end
        if (install_valid && install_line == line)
        begin
            return 0;
        end
        return ent_line_q.size() < cache_pkg::mshr_rows;
    endfunction

    task automatic check(input string field, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act)
        begin
            $display("mismatch %s %s expected %h actual %h", test_name, field, exp, act);
            $display("Testbench failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic take_request();
        int lat;
        if (exp_cmd_q.size() == 0)
        begin
            $display("%s: memory request with no miss waiting for it", test_name);
            $display("Testbench failed");
            $fatal(1, "stopped at first error");
        end
        check("cmd", 128'(exp_cmd_q.pop_front()), 128'(mem_cmd));
        check("req_addr", 128'(exp_addr_q.pop_front()), 128'(mem_req_addr));
        if (mem_cmd == mem_pkg::cmd_write)
        begin
            check("req_data", exp_data_q.pop_front(), mem_req_data);
            mem_store[mem_req_addr] = mem_req_data;
        end
        else
        begin
            void'(exp_data_q.pop_front());
            lat = 1 + int'(take_bits(2));
            due_q.push_back(cycles + lat);
            resp_q.push_back(mem_store.exists(mem_req_addr) ? mem_store[mem_req_addr]
                                                             : mem_fill(mem_req_addr));
        end
    endtask

    // One clock cycle: check the outputs, then drive new inputs on the falling edge.
    task automatic step(input cache_pkg::dop_t o, input logic [27:0] line, input logic h,
                        input logic d, input logic [18:0] t, input logic [127:0] dat);
        logic [31:0] r;
        bit          acc;
        @(negedge g);
        check("refill_valid", 128'(install_valid), 128'(refill_valid));
        if (install_valid)
        begin
            check("refill_addr", 128'(install_line), 128'(refill_addr));
            check("refill_data", install_data, refill_data);
        end
        check("mshr_full", 128'(ent_line_q.size() == cache_pkg::mshr_rows), 128'(mshr_full));
        if (prev_stall)
        begin
            check("held_valid", 128'(1), 128'(mem_req_valid));
            check("held_cmd", 128'(prev_cmd), 128'(mem_cmd));
            check("held_addr", 128'(prev_addr), 128'(mem_req_addr));
            check("held_data", prev_data, mem_req_data);
        end
        r = take_bits(4);
        op = o;
        addr = {line, r[3:0]};
        hit = h;
        dirty = d;
        tag = t;
        data = dat;
        mem_req_ready = stall_mode ? (take_bits(2) != 32'd0) : 1'b1;
        mem_resp_valid = 1'b0;
        if (!hold_resp && resp_q.size() > 0 && due_q[0] <= cycles)
        begin
            mem_resp_valid = 1'b1;
            mem_resp_data = resp_q.pop_front();
            void'(due_q.pop_front());
        end
        if (mem_req_valid && mem_req_ready)
        begin
            take_request();
        end
        // Reference update for the coming rising edge.
        acc = ref_accepts(o, h, line);
        install_valid = mem_resp_valid;
        if (mem_resp_valid)
        begin
            install_line = ent_line_q.pop_front();
            install_data = ent_fill_q.pop_front();
        end
        if (acc)
        begin
            if (d)
            begin
                exp_cmd_q.push_back(mem_pkg::cmd_write);
                exp_addr_q.push_back({t, line[8:0]});
                exp_data_q.push_back(dat);
                shadow[{t, line[8:0]}] = dat;
            end
            exp_cmd_q.push_back(mem_pkg::cmd_read);
            exp_addr_q.push_back(line);
            exp_data_q.push_back('0);
            ent_line_q.push_back(line);
            ent_fill_q.push_back(shadow.exists(line) ? shadow[line] : mem_fill(line));
        end
        prev_stall = mem_req_valid && !mem_req_ready;
        prev_cmd = mem_cmd;
        prev_addr = mem_req_addr;
        prev_data = mem_req_data;
    endtask

    task automatic idle();
        step(cache_pkg::dop_none, '0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic drain();
        while (ent_line_q.size() > 0 || install_valid || resp_q.size() > 0
               || exp_cmd_q.size() > 0)
        begin
            idle();
        end
        // With nothing outstanding the memory port must stay quiet.
        repeat (4) idle();
        check("quiet_req_valid", 128'(0), 128'(mem_req_valid));
    endtask

    task automatic random_lookup();
        logic [31:0]     r;
        logic [31:0]     k;
        logic [31:0]     t;
        cache_pkg::dop_t o;
        logic            h;
        logic            d;
        r = take_bits(2);
        case (r[1:0])
            2'd0: o = cache_pkg::dop_none;
            2'd2: o = cache_pkg::dop_w;
            default: o = cache_pkg::dop_r;
        endcase
        h = (take_bits(2) == 32'd0);
        d = (take_bits(1) == 32'd1);
        k = take_bits(3);
        t = take_bits(19);
        step(o, pool_line(k[2:0]), h, d, t[18:0],
             {take_bits(32), take_bits(32), take_bits(32), take_bits(32)});
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------

    initial
    begin
        rst = 1'b1;
        op = cache_pkg::dop_none;
        addr = '0;
        hit = 1'b0;
        dirty = 1'b0;
        tag = '0;
        data = '0;
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data = '0;
        repeat (16) @(negedge g);
        rst = 1'b0;

        test_name = "single_read";
        step(cache_pkg::dop_r, 28'h0123456, 1'b0, 1'b0, '0, '0);
        drain();

        test_name = "dirty_victim";
        step(cache_pkg::dop_w, 28'h0200011, 1'b0, 1'b1, 19'h5a5a5, {4{32'hc0ffee11}});
        drain();
        step(cache_pkg::dop_r, {19'h5a5a5, 9'h011}, 1'b0, 1'b0, '0, '0);
        drain();

        test_name = "merge";
        repeat (len_merge)
        begin
            step(cache_pkg::dop_r, 28'h0333000, 1'b0, 1'b1, 19'h00777, {4{32'h0badf00d}});
        end
        drain();

        test_name = "ready_stalls";
        stall_mode = 1;
        repeat (len_stall)
        begin
            random_lookup();
        end
        drain();
        stall_mode = 0;

        test_name = "mshr_full";
        hold_resp = 1;
        for (int i = 0; i < 9; i++)
        begin
            step(cache_pkg::dop_r, {16'h0b00, 3'd0, 9'(i)}, 1'b0, 1'b0, '0, '0);
        end
        repeat (4) idle();
        check("full_after_eight", 128'(1), 128'(mshr_full));
        hold_resp = 0;
        drain();

        test_name = "random_mix";
        stall_mode = 1;
        repeat (len_mix)
        begin
            random_lookup();
        end
        drain();

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: dcache_miss_path.f
design/cache_pkg.sv
design/mem_pkg.sv
design/writeback_handler.sv
design/load_handler.sv
design/mem_listener.sv
design/mem_request_mux.sv
design/miss_handler.sv
design/dcache_miss_path.sv
bench/dcache_miss_path_tb.sv

// File: Makefile
SRCS := $(shell cat dcache_miss_path.f)

.PHONY: run clean

run: obj_dir/Vdcache_miss_path_tb
	./obj_dir/Vdcache_miss_path_tb | tee /dev/stderr | grep -q "Testbench passed"

obj_dir/Vdcache_miss_path_tb: dcache_miss_path.f $(SRCS)
	verilator --binary --timing -f dcache_miss_path.f --top-module dcache_miss_path_tb

clean:
	rm -rf obj_dir
